//--- logic/mpram_cfg_pkg.sv
`default_nettype none

package mpram_cfg_pkg;

   // memory geometry.
   localparam int data_w    = 8;
   localparam int addr_w    = 5;
   localparam int mem_words = 24;   // addresses 24..31 are out of range.

   typedef logic [data_w-1:0] data_t;
   typedef logic [addr_w-1:0] addr_t;

endpackage

`default_nettype wire

//--- logic/mpram_mode_pkg.sv
`default_nettype none

package mpram_mode_pkg;

   // read mode, decoded once per sampled cycle in the read port.
   typedef enum logic [1:0]
   {
      mode_data = 2'b00,   // normal read.
      mode_off  = 2'b01,   // output enable inactive.
      mode_pd   = 2'b10    // powered down.
   } rd_mode_e;

   // fill bits, replicated over the data word by the core.
   localparam logic pd_pattern  = 1'b1;   // all ones.
   localparam logic off_pattern = 1'b0;   // disabled or bad address.

endpackage

`default_nettype wire

//--- logic/mpram_wr_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mpram_wr_if
#(
   parameter int DATA_W = mpram_cfg_pkg::data_w,
   parameter int ADDR_W = mpram_cfg_pkg::addr_w
);

   logic              en;     // store data at addr on the next edge.
   logic [ADDR_W-1:0] addr;
   logic [DATA_W-1:0] data;
   logic              err;    // rejected write, one cycle.

   modport wr_src
   (
      output en,
      output addr,
      output data,
      output err
   );

   modport wr_dst
   (
      input en,
      input addr,
      input data,
      input err
   );

endinterface

`default_nettype wire

//--- logic/mpram_rd_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mpram_rd_if
#(
   parameter int ADDR_W = mpram_cfg_pkg::addr_w
);

   import mpram_mode_pkg::*;

   logic              req;    // high every sampled cycle after reset.
   logic [ADDR_W-1:0] addr;
   rd_mode_e          mode;
   logic              bad;    // out of range, only in mode_data.

   modport rd_src
   (
      output req,
      output addr,
      output mode,
      output bad
   );

   // core takes mode and bad as they come.
   modport rd_dst
   (
      input req,
      input addr,
      input mode,
      input bad
   );

endinterface

`default_nettype wire

//--- logic/mpram_write_port.sv
`timescale 1ns/1ps
`default_nettype none

module mpram_write_port
#(
   parameter int DATA_W = mpram_cfg_pkg::data_w,
   parameter int ADDR_W = mpram_cfg_pkg::addr_w,
   parameter int WORDS  = mpram_cfg_pkg::mem_words
)
(
   input  logic              clk,
   input  logic              rst_n,
   input  logic              we_n,
   input  logic [ADDR_W-1:0] waddr,
   input  logic [DATA_W-1:0] din,
   mpram_wr_if.wr_src        wr
);

   // highest legal address.
   localparam int unsigned LAST = WORDS - 1;

   logic in_range;

   assign in_range = (waddr <= ADDR_W'(LAST));

   // strobe decode, en and err are exclusive.
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         wr.en  <= 1'b0;
         wr.err <= 1'b0;
      end
      else
      begin
         wr.en  <= !we_n && in_range;
         wr.err <= !we_n && !in_range;   // memory left untouched.
      end
   end

   // payload, only meaningful while en is high.
   always_ff @(posedge clk)
   begin
      wr.addr <= waddr;
      wr.data <= din;
   end

endmodule

`default_nettype wire

//--- logic/mpram_read_port.sv
`timescale 1ns/1ps
`default_nettype none

module mpram_read_port
#(
   parameter int ADDR_W = mpram_cfg_pkg::addr_w,
   parameter int WORDS  = mpram_cfg_pkg::mem_words
)
(
   input  logic              clk,
   input  logic              rst_n,
   input  logic              oe_n,
   input  logic              pd_n,
   input  logic [ADDR_W-1:0] raddr,
   mpram_rd_if.rd_src        rd
);

   import mpram_mode_pkg::*;

   localparam int unsigned LAST = WORDS - 1;

   rd_mode_e mode_d;
   logic     bad_d;

   // power-down wins over output enable.
   always_comb
   begin
      if (!pd_n)
         mode_d = mode_pd;
      else if (oe_n)
         mode_d = mode_off;
      else
         mode_d = mode_data;
   end

   // range error only counts for a real read.
   assign bad_d = (mode_d == mode_data) && (raddr > ADDR_W'(LAST));

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         rd.req  <= 1'b0;
         rd.mode <= mode_off;
         rd.bad  <= 1'b0;
      end
      else
      begin
         rd.req  <= 1'b1;   // new read every cycle.
         rd.mode <= mode_d;
         rd.bad  <= bad_d;
      end
   end

   always_ff @(posedge clk)
   begin
      rd.addr <= raddr;
   end

endmodule

`default_nettype wire

//--- logic/mpram_core.sv
`timescale 1ns/1ps
`default_nettype none

module mpram_core
#(
   parameter int DATA_W = mpram_cfg_pkg::data_w,
   parameter int ADDR_W = mpram_cfg_pkg::addr_w,
   parameter int WORDS  = mpram_cfg_pkg::mem_words
)
(
   input  logic              clk,
   input  logic              rst_n,
   mpram_wr_if.wr_dst        wr,
   mpram_rd_if.rd_dst        rd0,
   mpram_rd_if.rd_dst        rd1,
   mpram_rd_if.rd_dst        rd2,
   output logic [DATA_W-1:0] dout0,
   output logic [DATA_W-1:0] dout1,
   output logic [DATA_W-1:0] dout2,
   output logic [2:0]        rd_err,
   output logic              wr_err
);

   import mpram_mode_pkg::*;

   logic [DATA_W-1:0] mem [WORDS];

   // output word for one read request.
   function automatic logic [DATA_W-1:0] rd_word
   (
      input rd_mode_e          mode,
      input logic              bad,
      input logic [ADDR_W-1:0] addr
   );
      logic [DATA_W-1:0] word;
      case (mode)
         mode_pd:   word = {DATA_W{pd_pattern}};
         mode_data:
         begin
            if (bad)
               word = {DATA_W{off_pattern}};
            else
               word = mem[addr];
         end
         default:   word = {DATA_W{off_pattern}};
      endcase
      return word;
   endfunction

   // single write port, address already checked.
   always_ff @(posedge clk)
   begin
      if (wr.en)
         mem[wr.addr] <= wr.data;
   end

   // registered read outputs and error flags.
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         dout0  <= '0;
         dout1  <= '0;
         dout2  <= '0;
         rd_err <= '0;
         wr_err <= 1'b0;
      end
      else
      begin
         if (rd0.req)
         begin
            dout0     <= rd_word(rd0.mode, rd0.bad, rd0.addr);
            rd_err[0] <= rd0.bad;
         end
         if (rd1.req)
         begin
            dout1     <= rd_word(rd1.mode, rd1.bad, rd1.addr);
            rd_err[1] <= rd1.bad;
         end
         if (rd2.req)
         begin
            dout2     <= rd_word(rd2.mode, rd2.bad, rd2.addr);
            rd_err[2] <= rd2.bad;
         end
         wr_err <= wr.err;   // one-cycle pulse.
      end
   end

endmodule

`default_nettype wire

//--- logic/mpram_3r1w.sv
`timescale 1ns/1ps
`default_nettype none

module mpram_3r1w
#(
   parameter int DATA_W = mpram_cfg_pkg::data_w,
   parameter int ADDR_W = mpram_cfg_pkg::addr_w,
   parameter int WORDS  = mpram_cfg_pkg::mem_words
)
(
   input  logic              clk,
   input  logic              rst_n,
   input  logic              we_n,
   input  logic [ADDR_W-1:0] waddr,
   input  logic [DATA_W-1:0] din,
   input  logic [2:0]        oe_n,
   input  logic              pd_n,    // shared by all read ports.
   input  logic [ADDR_W-1:0] raddr0,
   input  logic [ADDR_W-1:0] raddr1,
   input  logic [ADDR_W-1:0] raddr2,
   output logic [DATA_W-1:0] dout0,
   output logic [DATA_W-1:0] dout1,
   output logic [DATA_W-1:0] dout2,
   output logic [2:0]        rd_err,
   output logic              wr_err
);

   mpram_wr_if #(.DATA_W(DATA_W), .ADDR_W(ADDR_W)) wr_if ();
   mpram_rd_if #(.ADDR_W(ADDR_W)) rd0_if ();
   mpram_rd_if #(.ADDR_W(ADDR_W)) rd1_if ();
   mpram_rd_if #(.ADDR_W(ADDR_W)) rd2_if ();

   mpram_write_port #(.DATA_W(DATA_W), .ADDR_W(ADDR_W), .WORDS(WORDS)) u_write_port
   (
      .clk   (clk),
      .rst_n (rst_n),
      .we_n  (we_n),
      .waddr (waddr),
      .din   (din),
      .wr    (wr_if.wr_src)
   );

   mpram_read_port #(.ADDR_W(ADDR_W), .WORDS(WORDS)) u_read_port0
   (
      .clk   (clk),
      .rst_n (rst_n),
      .oe_n  (oe_n[0]),
      .pd_n  (pd_n),
      .raddr (raddr0),
      .rd    (rd0_if.rd_src)
   );

   mpram_read_port #(.ADDR_W(ADDR_W), .WORDS(WORDS)) u_read_port1
   (
      .clk   (clk),
      .rst_n (rst_n),
      .oe_n  (oe_n[1]),
      .pd_n  (pd_n),
      .raddr (raddr1),
      .rd    (rd1_if.rd_src)
   );

   mpram_read_port #(.ADDR_W(ADDR_W), .WORDS(WORDS)) u_read_port2
   (
      .clk   (clk),
      .rst_n (rst_n),
      .oe_n  (oe_n[2]),
      .pd_n  (pd_n),
      .raddr (raddr2),
      .rd    (rd2_if.rd_src)
   );

   mpram_core #(.DATA_W(DATA_W), .ADDR_W(ADDR_W), .WORDS(WORDS)) u_core
   (
      .clk    (clk),
      .rst_n  (rst_n),
      .wr     (wr_if.wr_dst),
      .rd0    (rd0_if.rd_dst),
      .rd1    (rd1_if.rd_dst),
      .rd2    (rd2_if.rd_dst),
      .dout0  (dout0),
      .dout1  (dout1),
      .dout2  (dout2),
      .rd_err (rd_err),
      .wr_err (wr_err)
   );

endmodule

`default_nettype wire

//--- verif/tb_mpram_3r1w.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mpram_3r1w;

   import mpram_cfg_pkg::*;

   logic       clk;
   logic       rst_n;
   logic       we_n;
   addr_t      waddr;
   data_t      din;
   logic [2:0] oe_n;
   logic       pd_n;
   addr_t      raddr0;
   addr_t      raddr1;
   addr_t      raddr2;
   data_t      dout0;
   data_t      dout1;
   data_t      dout2;
   logic [2:0] rd_err;
   logic       wr_err;
   logic [3:0] err_flags;
   logic       wr_ok;

   // reference model, two stages behind the sampled inputs.
   data_t       shadow [mem_words];
   logic        known [mem_words];
   data_t [2:0] exp1;
   data_t [2:0] exp2;
   logic [2:0]  vld1;
   logic [2:0]  vld2;
   logic [2:0]  bad1;
   logic [2:0]  bad2;
   logic        wer1;
   logic        wer2;

   int seed = 32'h15c9_45d9;
   int err_count;
   int tests_run;
   int tests_failed;

   mpram_3r1w #(.DATA_W(data_w), .ADDR_W(addr_w), .WORDS(mem_words)) u_mpram_3r1w
   (
      .clk    (clk),
      .rst_n  (rst_n),
      .we_n   (we_n),
      .waddr  (waddr),
      .din    (din),
      .oe_n   (oe_n),
      .pd_n   (pd_n),
      .raddr0 (raddr0),
      .raddr1 (raddr1),
      .raddr2 (raddr2),
      .dout0  (dout0),
      .dout1  (dout1),
      .dout2  (dout2),
      .rd_err (rd_err),
      .wr_err (wr_err)
   );

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   assign err_flags = {wr_err, rd_err};
   assign wr_ok     = !we_n && in_range(waddr);

   function automatic logic in_range(input addr_t a);
      return int'(a) < mem_words;
   endfunction

   // power-down first, then disable, then range.
   function automatic data_t expect_word(input logic oe_b, input logic pd_b, input addr_t a);
      if (!pd_b)
         return '1;
      else if (oe_b || !in_range(a))
         return '0;
      else
         return shadow[a];
   endfunction

   function automatic logic expect_bad(input logic oe_b, input logic pd_b, input addr_t a);
      return pd_b && !oe_b && !in_range(a);
   endfunction

   // data reads of unwritten words or same-cycle writes are undefined.
   function automatic logic comparable
   (
      input logic  oe_b,
      input logic  pd_b,
      input addr_t a,
      input logic  hit
   );
      if (!pd_b || oe_b || !in_range(a))
         return 1'b1;
      else
         return known[a] && !hit;
   endfunction

   always @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         exp1 <= '0;
         exp2 <= '0;
         vld1 <= '0;
         vld2 <= '0;
         bad1 <= '0;
         bad2 <= '0;
         wer1 <= 1'b0;
         wer2 <= 1'b0;
         for (int i = 0; i < mem_words; i++)
            known[i] <= 1'b0;
      end
      else
      begin
         exp1[0] <= expect_word(oe_n[0], pd_n, raddr0);
         exp1[1] <= expect_word(oe_n[1], pd_n, raddr1);
         exp1[2] <= expect_word(oe_n[2], pd_n, raddr2);
         vld1[0] <= comparable(oe_n[0], pd_n, raddr0, wr_ok && waddr == raddr0);
         vld1[1] <= comparable(oe_n[1], pd_n, raddr1, wr_ok && waddr == raddr1);
         vld1[2] <= comparable(oe_n[2], pd_n, raddr2, wr_ok && waddr == raddr2);
         bad1    <= {expect_bad(oe_n[2], pd_n, raddr2), expect_bad(oe_n[1], pd_n, raddr1),
                     expect_bad(oe_n[0], pd_n, raddr0)};
         wer1    <= !we_n && !in_range(waddr);
         exp2    <= exp1;
         vld2    <= vld1;
         bad2    <= bad1;
         wer2    <= wer1;
         if (wr_ok)
         begin
            shadow[waddr] <= din;   // old word still seen this edge.
            known[waddr]  <= 1'b1;
         end
      end
   end

   assert property (@(posedge clk) disable iff (!rst_n) vld2[0] |-> dout0 == exp2[0])
      else report_value("dout0", 32'(exp2[0]), 32'(dout0));
   assert property (@(posedge clk) disable iff (!rst_n) vld2[1] |-> dout1 == exp2[1])
      else report_value("dout1", 32'(exp2[1]), 32'(dout1));
   assert property (@(posedge clk) disable iff (!rst_n) vld2[2] |-> dout2 == exp2[2])
      else report_value("dout2", 32'(exp2[2]), 32'(dout2));
   assert property (@(posedge clk) disable iff (!rst_n) rd_err == bad2)
      else report_value("rd_err", 32'(bad2), 32'(rd_err));
   assert property (@(posedge clk) disable iff (!rst_n) wr_err == wer2)
      else report_value("wr_err", 32'(wer2), 32'(wr_err));

   task automatic report_value(input string name, input logic [31:0] exp, input logic [31:0] act);
      err_count++;
      $display("[ERROR] %s expected 0x%0h actual 0x%0h at %0t", name, exp, act, $time);
   endtask

   task automatic report_failure(input string msg);
      err_count++;
      $display("error: %s at %0t", msg, $time);
   endtask

   function automatic int next_rand();
      return $random(seed);
   endfunction

   function automatic addr_t in_range_addr();
      return addr_t'($unsigned(next_rand()) % mem_words);
   endfunction

   function automatic addr_t out_of_range_addr();
      return addr_t'(mem_words + $unsigned(next_rand()) % ((1 << addr_w) - mem_words));
   endfunction

   function automatic data_t random_data();
      return data_t'(next_rand());
   endfunction

   task automatic drive
   (
      input logic       w_n,
      input addr_t      wa,
      input data_t      d,
      input logic [2:0] oe,
      input logic       pd,
      input addr_t      a0,
      input addr_t      a1,
      input addr_t      a2
   );
      @(posedge clk);
      we_n   <= w_n;
      waddr  <= wa;
      din    <= d;
      oe_n   <= oe;
      pd_n   <= pd;
      raddr0 <= a0;
      raddr1 <= a1;
      raddr2 <= a2;
   endtask

   task automatic idle(input int cycles);
      for (int n = 0; n < cycles; n++)
         drive(1'b1, '0, '0, 3'b111, 1'b1, '0, '0, '0);
   endtask

   // every word once per port, the three ports on different words.
   task automatic read_all();
      for (int i = 0; i < mem_words; i++)
         drive(1'b1, '0, '0, 3'b000, 1'b1, addr_t'(i), addr_t'((i + 8) % mem_words),
               addr_t'((i + 16) % mem_words));
   endtask

   task automatic wait_error(input int idx, input string name);
      int cycles;
      cycles = 0;
      do
      begin
         @(negedge clk);
         cycles++;
      end
      while (!err_flags[idx] && cycles < 6);
      if (!err_flags[idx])
         report_failure({name, " never rose after an out-of-range access"});
   endtask

   task automatic close_test(input string name, input int start);
      idle(4);   // drains the two-edge read pipeline.
      tests_run++;
      if (err_count != start)
      begin
         tests_failed++;
         $display("test %s: failed with %0d errors", name, err_count - start);
      end
      else
         $display("test %s: passed", name);
   endtask

   task automatic reset_state();
      int start;
      start = err_count;
      @(posedge clk);
      @(negedge clk);
      assert (dout0 == '0) else report_value("dout0", 32'h0, 32'(dout0));
      assert (dout1 == '0) else report_value("dout1", 32'h0, 32'(dout1));
      assert (dout2 == '0) else report_value("dout2", 32'h0, 32'(dout2));
      assert (rd_err == 3'b000) else report_value("rd_err", 32'h0, 32'(rd_err));
      assert (wr_err == 1'b0) else report_value("wr_err", 32'h0, 32'(wr_err));
      @(posedge clk);
      rst_n <= 1'b1;
      close_test("reset state", start);
   endtask

   task automatic write_then_read();
      int start;
      addr_t a;
      start = err_count;
      for (int i = 0; i < mem_words; i++)
         drive(1'b0, addr_t'(i), random_data(), 3'b111, 1'b1, '0, '0, '0);
      idle(2);
      read_all();
      for (int n = 0; n < 16; n++)
      begin
         a = in_range_addr();
         drive(1'b0, a, random_data(), 3'b111, 1'b1, '0, '0, '0);
         idle(1);
         drive(1'b1, '0, '0, 3'b000, 1'b1, a, a, a);
      end
      close_test("write then read", start);
   endtask

   task automatic invalid_write();
      int start;
      start = err_count;
      for (int n = 0; n < (1 << addr_w) - mem_words; n++)
      begin
         drive(1'b0, addr_t'(mem_words + n), random_data(), 3'b111, 1'b1, '0, '0, '0);
         idle(1);
         wait_error(3, "wr_err");
      end
      read_all();
      close_test("invalid write", start);
   endtask

   task automatic invalid_read();
      int start;
      addr_t ra [3];
      start = err_count;
      for (int n = 0; n < 12; n++)
      begin
         for (int k = 0; k < 3; k++)
            ra[k] = in_range_addr();
         ra[n % 3] = out_of_range_addr();
         drive(1'b1, '0, '0, 3'b000, 1'b1, ra[0], ra[1], ra[2]);
         idle(1);
         wait_error(n % 3, $sformatf("rd_err[%0d]", n % 3));
      end
      close_test("invalid read", start);
   endtask

   task automatic output_modes();
      int start;
      start = err_count;
      for (int n = 0; n < 8; n++)
         drive(1'b1, '0, '0, 3'(n), 1'b1, in_range_addr(), in_range_addr(), in_range_addr());
      // power-down with bad addresses, writes keep landing.
      for (int n = 0; n < 16; n++)
         drive(1'b0, in_range_addr(), random_data(), 3'(n), 1'b0, out_of_range_addr(),
               out_of_range_addr(), in_range_addr());
      idle(2);
      read_all();
      close_test("output modes", start);
   endtask

   task automatic random_traffic();
      int start;
      int r;
      start = err_count;
      for (int n = 0; n < 300; n++)
      begin
         r = next_rand();
         drive(r[0], addr_t'(next_rand()), random_data(), r[3:1] & r[6:4], r[9:7] != 3'b000,
               addr_t'(next_rand()), addr_t'(next_rand()), addr_t'(next_rand()));
      end
      close_test("random traffic", start);
   endtask

   initial
   begin
      err_count    = 0;
      tests_run    = 0;
      tests_failed = 0;
      rst_n        = 1'b0;
      we_n         = 1'b1;
      waddr        = '0;
      din          = '0;
      oe_n         = 3'b111;
      pd_n         = 1'b1;
      raddr0       = '0;
      raddr1       = '0;
      raddr2       = '0;
      reset_state();
      write_then_read();
      invalid_write();
      invalid_read();
      output_modes();
      random_traffic();
      $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
               err_count);
      if (err_count == 0 && tests_failed == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- tb.f
logic/mpram_cfg_pkg.sv
logic/mpram_mode_pkg.sv
logic/mpram_wr_if.sv
logic/mpram_rd_if.sv
logic/mpram_write_port.sv
logic/mpram_read_port.sv
logic/mpram_core.sv
logic/mpram_3r1w.sv
verif/tb_mpram_3r1w.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_mpram_3r1w -o sim_mpram_3r1w

out=$(./obj_dir/sim_mpram_3r1w)
echo "$out"

if echo "$out" | grep -qx "ALL TESTS PASSED"; then
   exit 0
fi
exit 1
